// ==== verilog/mmu_pkg.sv ====
/* Sv32 translation types shared by the MMU blocks and the testbench.
   Import with mmu_pkg::* in the module header. */
package mmu_pkg;

    localparam int VPN_BITS         = 20;
    localparam int PPN_BITS         = 22;
    localparam int PAGE_OFFSET_BITS = 12;
    localparam int PADDR_BITS       = 34;
    localparam int TLB_INDEX_BITS   = 4;
    localparam int TLB_ENTRIES      = 2 ** TLB_INDEX_BITS;
    localparam int TLB_TAG_BITS     = VPN_BITS - TLB_INDEX_BITS;

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } vpn_t;

    typedef logic [PPN_BITS-1:0] ppn_t;

    // pte flags with valid at bit 0
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } access_bits_t;

    typedef struct packed {
        logic [11:0]  ppn1;
        logic [9:0]   ppn0;
        logic [1:0]   rsw;
        access_bits_t access;
    } pte_leaf_t;

    typedef struct packed {
        ppn_t         ppn;
        logic [1:0]   rsw;
        access_bits_t access;
    } pte_pointer_t;

    // the same word is read as a leaf or as a pointer to the next table
    typedef union packed {
        pte_leaf_t    leaf;
        pte_pointer_t pointer;
    } pte_t;

    typedef struct packed {
        logic mode;
        ppn_t ppn;
    } satp_t;

    typedef struct packed {
        logic                  done;
        logic                  pagefault;
        logic                  accessfault;
        logic [PADDR_BITS-1:0] physical_address;
        access_bits_t          access_bits;
    } xlate_result_t;

    localparam access_bits_t BARE_ACCESS_BITS = '{
        d: 1'b1, a: 1'b1, g: 1'b0, u: 1'b0,
        x: 1'b1, w: 1'b1, r: 1'b1, v: 1'b1
    };

endpackage

// ==== verilog/bus_pkg.sv ====
/* Command and response codes of the read-only memory bus and the request and
   response bundles that carry them between master and memory. */
package bus_pkg;

    localparam int BUS_ADDR_BITS = 34;
    localparam int BUS_DATA_BITS = 32;

    typedef enum logic [2:0] {
        BUS_CMD_NONE  = 3'd0,
        BUS_CMD_READ  = 3'd1,
        BUS_CMD_WRITE = 3'd2
    } bus_cmd_e;

    typedef enum logic [2:0] {
        BUS_RESP_SUCCESS      = 3'd0,
        BUS_RESP_DECODE_ERROR = 3'd1,
        BUS_RESP_SLAVE_ERROR  = 3'd2
    } bus_resp_e;

    // transaction stays high with a steady address until done
    typedef struct packed {
        logic                     transaction;
        bus_cmd_e                 cmd;
        logic [BUS_ADDR_BITS-1:0] address;
    } bus_req_t;

    typedef struct packed {
        logic                     done;
        bus_resp_e                response;
        logic [BUS_DATA_BITS-1:0] rdata;
    } bus_rsp_t;

endpackage

// ==== verilog/tlb.sv ====
/* Direct-mapped Sv32 TLB with combinational lookup, one refill port and a
   flush that drops every entry on the next edge. */
`timescale 1ns/1ps
module tlb
    import mmu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         flush,

    input  vpn_t         lookup_vpn,
    output logic         hit,
    output ppn_t         hit_ppn,
    output access_bits_t hit_access_bits,

    input  logic         fill,
    input  vpn_t         fill_vpn,
    input  ppn_t         fill_ppn,
    input  access_bits_t fill_access_bits
);

    typedef struct packed {
        logic [TLB_TAG_BITS-1:0] tag;
        ppn_t                    ppn;
        access_bits_t            access_bits;
    } tlb_entry_t;

    logic [TLB_ENTRIES-1:0]    valid;
    tlb_entry_t                entries [TLB_ENTRIES];

    logic [VPN_BITS-1:0]       lookup_bits;
    logic [VPN_BITS-1:0]       fill_bits;
    logic [TLB_INDEX_BITS-1:0] lookup_index;
    logic [TLB_TAG_BITS-1:0]   lookup_tag;
    logic [TLB_INDEX_BITS-1:0] fill_index;
    logic [TLB_TAG_BITS-1:0]   fill_tag;
    tlb_entry_t                lookup_entry;

    // low vpn bits pick the slot, the rest is the tag
    assign lookup_bits  = lookup_vpn;
    assign fill_bits    = fill_vpn;
    assign lookup_index = lookup_bits[TLB_INDEX_BITS-1:0];
    assign lookup_tag   = lookup_bits[VPN_BITS-1:TLB_INDEX_BITS];
    assign fill_index   = fill_bits[TLB_INDEX_BITS-1:0];
    assign fill_tag     = fill_bits[VPN_BITS-1:TLB_INDEX_BITS];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign lookup_entry    = entries[lookup_index];
    assign hit             = valid[lookup_index] && (lookup_entry.tag == lookup_tag);
    assign hit_ppn         = lookup_entry.ppn;
    assign hit_access_bits = lookup_entry.access_bits;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // refill and flush
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
        end else begin
            if (flush) begin
                valid <= '0;
            end
            if (fill) begin
                valid[fill_index] <= 1'b1;  // a refill in the flush cycle survives
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            entries[fill_index] <= '{
                tag:         fill_tag,
                ppn:         fill_ppn,
                access_bits: fill_access_bits
            };
        end
    end

endmodule

// ==== verilog/page_walker.sv ====
/* Two-level Sv32 page table walker. A walk_start strobe in idle starts a walk,
   the outcome is valid in the single walk_done cycle. */
`timescale 1ns/1ps
module page_walker
    import mmu_pkg::*;
    import bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         walk_start,
    input  vpn_t         vpn,
    input  ppn_t         root_ppn,

    output bus_req_t     m_req,
    input  bus_rsp_t     m_rsp,

    output logic         walk_done,
    output logic         walk_pagefault,
    output logic         walk_accessfault,
    output ppn_t         walk_ppn,
    output access_bits_t walk_access_bits
);

    typedef enum logic {
        ST_IDLE,
        ST_WALK
    } walk_state_e;

    walk_state_e state;
    logic        level;       // 1 for the root table, 0 for the leaf table
    ppn_t        table_base;
    vpn_t        saved_vpn;

    pte_t        pte;
    logic [9:0]  vpn_index;
    logic        bus_error;
    logic        pte_invalid;
    logic        pte_leaf;
    logic        pte_misaligned;
    logic        last_read;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus request
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign vpn_index = level ? saved_vpn.vpn1 : saved_vpn.vpn0;

    always_comb begin
        m_req.transaction = (state == ST_WALK);
        m_req.cmd         = (state == ST_WALK) ? BUS_CMD_READ : BUS_CMD_NONE;
        m_req.address     = {table_base, vpn_index, 2'b00}; // base * 4096 + index * 4
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entry classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pte       = m_rsp.rdata;
    assign bus_error = (m_rsp.response != BUS_RESP_SUCCESS);

    assign pte_invalid    = !pte.leaf.access.v || (pte.leaf.access.w && !pte.leaf.access.r);
    assign pte_leaf       = pte.leaf.access.r || pte.leaf.access.x; // otherwise a pointer
    assign pte_misaligned = level && (pte.leaf.ppn0 != '0);

    // only a valid pointer at level 1 keeps the walk going
    assign last_read = bus_error || pte_invalid || pte_leaf || !level;

    always_comb begin
        walk_done        = 1'b0;
        walk_pagefault   = 1'b0;
        walk_accessfault = 1'b0;
        if (state == ST_WALK && m_rsp.done && last_read) begin
            walk_done = 1'b1;
            if (bus_error) begin
                walk_accessfault = 1'b1;
            end else if (pte_invalid || !pte_leaf || pte_misaligned) begin
                walk_pagefault = 1'b1;
            end
        end
    end

    // a megapage maps vpn0 straight through
    assign walk_ppn         = {pte.leaf.ppn1, level ? saved_vpn.vpn0 : pte.leaf.ppn0};
    assign walk_access_bits = pte.leaf.access;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // walk state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (walk_start) begin
                        state <= ST_WALK;
                    end
                end
                ST_WALK: begin
                    if (m_rsp.done && last_read) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (walk_start) begin
                level      <= 1'b1;
                table_base <= root_ppn;
                saved_vpn  <= vpn;
            end
        end else if (m_rsp.done && !last_read) begin
            level      <= 1'b0;                 // descend through the pointer
            table_base <= pte.pointer.ppn;
        end
    end

endmodule

// ==== verilog/mmu_top.sv ====
/* Sv32 MMU top. Accepts one translation at a time, answers from bare mode or
   the TLB in one cycle and otherwise runs the page walker over the bus. */
`timescale 1ns/1ps
module mmu_top
    import mmu_pkg::*;
    import bus_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  logic          request,
    input  logic [31:0]   virtual_address,
    input  satp_t         satp,
    input  logic          tlb_flush,

    output logic          busy,
    output xlate_result_t result,

    output bus_req_t      m_req,
    input  bus_rsp_t      m_rsp
);

    typedef enum logic {
        ST_IDLE,
        ST_WALK
    } top_state_e;

    top_state_e   state;
    logic         accept;
    logic [31:0]  saved_va;
    ppn_t         saved_root;
    vpn_t         lookup_vpn;
    vpn_t         saved_vpn;

    logic         tlb_hit;
    ppn_t         tlb_ppn;
    access_bits_t tlb_access_bits;
    logic         tlb_fill;

    logic         walk_start;
    logic         walk_done;
    logic         walk_pagefault;
    logic         walk_accessfault;
    ppn_t         walk_ppn;
    access_bits_t walk_access_bits;

    assign busy       = (state != ST_IDLE) || result.done; // held through the done cycle
    assign accept     = request && !busy;
    assign lookup_vpn = virtual_address[31:PAGE_OFFSET_BITS];
    assign saved_vpn  = saved_va[31:PAGE_OFFSET_BITS];
    assign tlb_fill   = walk_done && !walk_pagefault && !walk_accessfault;

    tlb u_tlb (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (tlb_flush),
        .lookup_vpn       (lookup_vpn),
        .hit              (tlb_hit),
        .hit_ppn          (tlb_ppn),
        .hit_access_bits  (tlb_access_bits),
        .fill             (tlb_fill),
        .fill_vpn         (saved_vpn),
        .fill_ppn         (walk_ppn),
        .fill_access_bits (walk_access_bits)
    );

    page_walker u_page_walker (
        .clk              (clk),
        .rst_n            (rst_n),
        .walk_start       (walk_start),
        .vpn              (saved_vpn),
        .root_ppn         (saved_root),
        .m_req            (m_req),
        .m_rsp            (m_rsp),
        .walk_done        (walk_done),
        .walk_pagefault   (walk_pagefault),
        .walk_accessfault (walk_accessfault),
        .walk_ppn         (walk_ppn),
        .walk_access_bits (walk_access_bits)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request control and result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            walk_start  <= 1'b0;
            result.done <= 1'b0;
        end else begin
            result.done <= 1'b0;
            walk_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        saved_va   <= virtual_address;
                        saved_root <= satp.ppn;
                        if (!satp.mode) begin
                            result <= '{1'b1, 1'b0, 1'b0,
                                        {2'b00, virtual_address}, BARE_ACCESS_BITS};
                        end else if (tlb_hit) begin
                            result <= '{1'b1, 1'b0, 1'b0,
                                        {tlb_ppn, virtual_address[PAGE_OFFSET_BITS-1:0]},
                                        tlb_access_bits};
                        end else begin
                            walk_start <= 1'b1;
                            state      <= ST_WALK;
                        end
                    end
                end
                ST_WALK: begin
                    if (walk_done) begin
                        state              <= ST_IDLE;
                        result.done        <= 1'b1;
                        result.pagefault   <= walk_pagefault;
                        result.accessfault <= walk_accessfault;
                        if (tlb_fill) begin
                            result.physical_address <=
                                {walk_ppn, saved_va[PAGE_OFFSET_BITS-1:0]};
                            result.access_bits      <= walk_access_bits;
                        end else begin
                            result.physical_address <= '0; // faults carry no address
                            result.access_bits      <= '0;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== verification/mmu_tb.sv ====
/* Self-checking testbench for the Sv32 MMU. A page table memory model answers the
   walker, a reference walk over the same memory gives the expected results. */
`timescale 1ns/1ps
module mmu_tb
    import mmu_pkg::*;
    import bus_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int MEM_WORDS      = 16384;      // 64 KiB, table ppns 0 to 15
    localparam int ROOT_PPN       = 1;
    localparam int ERROR_PPN      = 6;
    localparam int DIRECTED_TESTS = 20;
    localparam int RANDOM_TESTS   = 200;
    localparam int WORST_CYCLES   = 2 * (4 + 2) + 6;  // two slow reads plus control overhead
    localparam int TIMEOUT_NS     =
        2 * (DIRECTED_TESTS + RANDOM_TESTS) * WORST_CYCLES * CLK_PERIOD + 1000;

    logic          clk;
    logic          rst_n;
    logic          request;
    logic [31:0]   virtual_address;
    satp_t         satp;
    logic          tlb_flush;
    logic          busy;
    xlate_result_t result;
    bus_req_t      m_req;
    bus_rsp_t      m_rsp;

    logic [31:0]   mem [MEM_WORDS];
    int unsigned   bus_count;
    int unsigned   seen_count;
    xlate_result_t exp_result_q [$];
    int unsigned   exp_count_q [$];
    logic          model_valid [16];
    vpn_t          model_vpn [16];

    mmu_top UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .request         (request),
        .virtual_address (virtual_address),
        .satp            (satp),
        .tlb_flush       (tlb_flush),
        .busy            (busy),
        .result          (result),
        .m_req           (m_req),
        .m_rsp           (m_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // page table memory and reference walk
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic bus_resp_e region_response(input logic [33:0] addr);
        if (addr[33:12] >= 22'(MEM_WORDS / 1024)) begin
            return BUS_RESP_DECODE_ERROR;
        end else if (addr[33:12] == 22'(ERROR_PPN)) begin
            return BUS_RESP_SLAVE_ERROR;
        end
        return BUS_RESP_SUCCESS;
    endfunction

    function automatic xlate_result_t reference_xlate(input logic [31:0] va, input satp_t s,
                                                      output int unsigned reads);
        xlate_result_t r;
        vpn_t          vpn;
        ppn_t          base;
        pte_t          pte;
        logic [33:0]   addr;
        logic          stop;
        r      = '0;
        r.done = 1'b1;
        reads  = 0;
        vpn    = va[31:12];
        base   = s.ppn;
        stop   = !s.mode;
        if (!s.mode) begin
            r.physical_address = {2'b00, va};
            r.access_bits      = 8'hcf;                 // v, r, w, x, a and d
        end
        for (int level = 1; level >= 0 && !stop; level--) begin
            addr  = {base, (level == 1) ? vpn.vpn1 : vpn.vpn0, 2'b00};
            reads = reads + 1;
            stop  = 1'b1;
            pte   = mem[addr[15:2]];
            if (region_response(addr) != BUS_RESP_SUCCESS) begin
                r.accessfault = 1'b1;
            end else if (!pte.leaf.access.v || (pte.leaf.access.w && !pte.leaf.access.r)) begin
                r.pagefault = 1'b1;
            end else if (pte.leaf.access.r || pte.leaf.access.x) begin
                if (level == 1 && pte.leaf.ppn0 != '0) begin
                    r.pagefault = 1'b1;                 // megapage must be aligned
                end else begin
                    r.physical_address = {pte.leaf.ppn1,
                                          (level == 1) ? vpn.vpn0 : pte.leaf.ppn0, va[11:0]};
                    r.access_bits      = pte.leaf.access;
                end
            end else if (level == 0) begin
                r.pagefault = 1'b1;
            end else begin
                base = pte.pointer.ppn;
                stop = 1'b0;
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] encode_pte(input ppn_t ppn, input logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] random_pte();
        logic [7:0] flags;
        flags = 8'($urandom);
        case ($urandom_range(0, 3))
            0:       return {22'($urandom_range(2, 6)), 2'b00, (flags & 8'hf0) | 8'h01};
            1:       return {22'($urandom), 2'b00, flags | 8'h03};
            2:       return {12'($urandom), 10'd0, 2'b00, flags | 8'h09};
            default: return $urandom;
        endcase
    endfunction

    task automatic write_pte(input int table_ppn, input int index, input logic [31:0] word);
        mem[14'(table_ppn * 1024 + index)] = word;
    endtask

    task automatic build_random_tables();
        for (int i = 0; i < 8; i++) begin
            write_pte(ROOT_PPN, i, random_pte());
            for (int t = 2; t < 6; t++) begin
                write_pte(t, i, random_pte());
            end
        end
    endtask

    initial begin : memory_model
        int          delay;
        logic [33:0] addr;
        m_rsp = '0;
        forever begin
            @(posedge clk);
            if (rst_n && m_req.transaction) begin
                compare_bus_cmd(m_req.cmd, BUS_CMD_READ);
                addr      = m_req.address;
                bus_count = bus_count + 1;
                delay     = $urandom_range(1, 4);
                repeat (delay - 1) begin
                    @(posedge clk);
                    if (!m_req.transaction || m_req.address !== addr) begin
                        $display("the bus request was dropped or moved before its response");
                        fail_run();
                    end
                end
                m_rsp <= '{done: 1'b1, response: region_response(addr), rdata: mem[addr[15:2]]};
                @(posedge clk);
                m_rsp <= '0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic fail_run();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_result(input xlate_result_t got, input xlate_result_t exp);
        if (got !== exp) begin
            $display("FAIL result: got %h expected %h", got, exp);
            fail_run();
        end
    endtask

    task automatic compare_bus_count(input int unsigned got, input int unsigned exp);
        if (got !== exp) begin
            $display("FAIL bus transaction count: got %h expected %h", got, exp);
            fail_run();
        end
    endtask

    task automatic compare_bus_cmd(input bus_cmd_e got, input bus_cmd_e exp);
        if (got !== exp) begin
            $display("FAIL m_req.cmd: got %h expected %h", got, exp);
            fail_run();
        end
    endtask

    task automatic compare_busy(input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL busy: got %h expected %h", got, exp);
            fail_run();
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && result.done) begin
            if (exp_result_q.size() == 0) begin
                $display("a result came back with no translation pending");
                fail_run();
            end else begin
                compare_result(result, exp_result_q.pop_front());
                compare_bus_count(bus_count - seen_count, exp_count_q.pop_front());
                seen_count = bus_count;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out waiting for a translation to finish");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] virtual_addr(input int vpn1, input int vpn0, input int offset);
        return {10'(vpn1), 10'(vpn0), 12'(offset)};
    endfunction

    task automatic translate(input logic [31:0] va, input satp_t s);
        xlate_result_t exp;
        int unsigned   reads;
        logic [3:0]    idx;
        idx = va[15:12];
        exp = reference_xlate(va, s, reads);
        if (s.mode && model_valid[idx] && model_vpn[idx] == vpn_t'(va[31:12])) begin
            reads = 0;                                  // served by the TLB
        end else if (s.mode && !exp.pagefault && !exp.accessfault) begin
            model_valid[idx] = 1'b1;
            model_vpn[idx]   = va[31:12];
        end
        exp_result_q.push_back(exp);
        exp_count_q.push_back(reads);
        @(posedge clk);
        compare_busy(busy, 1'b0);
        request         <= 1'b1;
        virtual_address <= va;
        satp            <= s;
        @(posedge clk);
        request <= 1'b0;
        do begin
            @(posedge clk);
            compare_busy(busy, 1'b1);                   // held from accept through done
        end while (!result.done);
    endtask

    task automatic flush_tlb();
        @(posedge clk);
        tlb_flush <= 1'b1;
        @(posedge clk);
        tlb_flush <= 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    initial begin : stimulus
        satp_t paged;
        satp_t bare;
        satp_t s;
        void'($urandom(61));
        rst_n           = 1'b0;
        request         = 1'b0;
        virtual_address = '0;
        satp            = '0;
        tlb_flush       = 1'b0;
        bus_count       = 0;
        seen_count      = 0;
        paged           = '{mode: 1'b1, ppn: 22'(ROOT_PPN)};
        bare            = '{mode: 1'b0, ppn: 22'(ROOT_PPN)};
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {i[13:0], i[13:0], 4'h0};          // invalid entries tagged with their index
        end
        write_pte(ROOT_PPN, 1, encode_pte(22'd2, 8'h01));
        write_pte(ROOT_PPN, 2, encode_pte({12'habc, 10'd0}, 8'hcb));
        write_pte(ROOT_PPN, 3, encode_pte({12'h123, 10'd5}, 8'h4b));
        write_pte(ROOT_PPN, 4, encode_pte(22'h3ffff, 8'h0e));
        write_pte(ROOT_PPN, 5, encode_pte(22'd9, 8'h05));
        write_pte(ROOT_PPN, 6, encode_pte(22'(ERROR_PPN), 8'h01));
        write_pte(ROOT_PPN, 7, encode_pte(22'd40, 8'h01));  // next table lies outside memory
        write_pte(2, 3, encode_pte(22'h2a5c3, 8'hcf));
        write_pte(2, 7, encode_pte(22'd3, 8'h01));
        write_pte(2, 8, encode_pte(22'h00011, 8'h85));

        repeat (8) @(posedge clk);
        if (result.done || busy || m_req.transaction) begin
            $display("the DUT outputs were not idle during reset");
            fail_run();
        end
        rst_n <= 1'b1;
        @(posedge clk);

        translate(32'hdead_beef, bare);
        translate(32'h0000_1234, bare);
        translate(virtual_addr(1, 3, 12'h5a4), paged);
        translate(virtual_addr(2, 9, 12'h010), paged);
        translate(virtual_addr(3, 0, 12'h000), paged);
        translate(virtual_addr(4, 1, 12'h111), paged);
        translate(virtual_addr(5, 2, 12'h222), paged);
        translate(virtual_addr(1, 7, 12'h333), paged);
        translate(virtual_addr(1, 8, 12'h444), paged);
        translate(virtual_addr(1, 20, 12'h555), paged);
        translate(virtual_addr(6, 0, 12'h666), paged);
        translate(virtual_addr(7, 0, 12'h777), paged);
        translate(virtual_addr(1, 3, 12'h004), paged);
        translate(virtual_addr(2, 9, 12'h7ff), paged);
        translate(virtual_addr(3, 0, 12'h000), paged); // faults are never cached
        flush_tlb();
        translate(virtual_addr(1, 3, 12'h5a4), paged);
        translate(virtual_addr(1, 3, 12'hffc), paged);

        build_random_tables();
        flush_tlb();
        s = paged;
        for (int n = 0; n < RANDOM_TESTS; n++) begin
            if ($urandom_range(0, 15) == 0) begin
                flush_tlb();
            end
            s.mode = ($urandom_range(0, 7) != 0);
            translate(virtual_addr($urandom_range(0, 7), $urandom_range(0, 7), $urandom), s);
        end

        repeat (4) @(posedge clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/mmu_pkg.sv
verilog/bus_pkg.sv
verilog/tlb.sv
verilog/page_walker.sv
verilog/mmu_top.sv
verification/mmu_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = mmu_tb
FILELIST  = filelist.f
BUILD     = obj_dir
PASS      = All tests passed

SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -Fxq "$(PASS)"

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
